//--- src/nrm_pkg.sv
// --------------------
// network router monitor package
// sizes, window length and record layout
// shared by every block of the monitor
// --------------------

package nrm_pkg;

   // router links under observation
   localparam int NUM_LINKS = 4;

   // width of a link index
   localparam int LINK_ID_WIDTH = 2;

   // link flit format, 32 data bits plus 2 type bits
   localparam int NOC_FLIT_DATA_WIDTH = 32;
   localparam int NOC_FLIT_TYPE_WIDTH = 2;
   localparam int NOC_FLIT_WIDTH = NOC_FLIT_DATA_WIDTH + NOC_FLIT_TYPE_WIDTH;

   // virtual channels per link, merged when counting
   localparam int NOC_VCHANNELS = 3;

   // flit count per window, saturates at the top value
   localparam int COUNT_WIDTH = 8;
   localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

   // measurement window in clock cycles
   localparam int SAMPLE_PERIOD = 300;
   localparam int SAMPLE_CNT_WIDTH = $clog2(SAMPLE_PERIOD);

   // statistics buffer geometry
   localparam int BUF_DEPTH = 16;
   localparam int BUF_ADDR_WIDTH = 4;

   // occupancy needs one bit more than the address to hold a full buffer
   localparam int BUF_LEVEL_WIDTH = BUF_ADDR_WIDTH + 1;

   // record layout: link index in the upper bits, count in the lower bits
   localparam int RECORD_WIDTH = LINK_ID_WIDTH + COUNT_WIDTH;
   localparam int RECORD_COUNT_LSB = 0;
   localparam int RECORD_LINK_LSB = COUNT_WIDTH;

   // grants seen in one burst, room for NUM_LINKS
   localparam int BURST_CNT_WIDTH = LINK_ID_WIDTH + 1;

endpackage

//--- src/nrm_link_statistics_collector.sv
// --------------------
// link statistics collector
// counts flits sent on one router link, saturating,
// and offers the sampled count as a pending record
// --------------------

`timescale 1ns/1ps

module nrm_link_statistics_collector (
   input  logic                                  clk,
   input  logic                                  rst,
   // router link, the payload is not decoded
   input  logic [nrm_pkg::NOC_FLIT_WIDTH-1:0]    flit,
   input  logic [nrm_pkg::NOC_VCHANNELS-1:0]     valid,
   input  logic [nrm_pkg::NOC_VCHANNELS-1:0]     ready,
   // window end from the sample timer
   input  logic                                  sample,
   // arbiter handshake
   input  logic                                  grant,
   output logic                                  req,
   output logic [nrm_pkg::COUNT_WIDTH-1:0]       sent_flits
);

   logic                               flit_sent;
   logic [nrm_pkg::COUNT_WIDTH-1:0]    flit_cnt;
   logic [nrm_pkg::COUNT_WIDTH-1:0]    flit_cnt_next;

   // a flit goes out when any channel has valid and ready together
   assign flit_sent = |(valid & ready);

   // count including this cycle, held at the top value
   always_comb begin
      flit_cnt_next = flit_cnt;
      if (flit_sent && (flit_cnt != nrm_pkg::COUNT_MAX)) begin
         flit_cnt_next = flit_cnt + 1'b1;
      end
   end

   // running counter, restarts at zero after each sample
   always_ff @(posedge clk) begin
      if (rst) begin
         flit_cnt <= '0;
      end else if (sample) begin
         flit_cnt <= '0;
      end else begin
         flit_cnt <= flit_cnt_next;
      end
   end

   // captured count of the closing window
   // includes a flit sent in the sample cycle itself
   always_ff @(posedge clk) begin
      if (sample) begin
         sent_flits <= flit_cnt_next;
      end
   end

   // request held as a level until the arbiter pulses grant
   always_ff @(posedge clk) begin
      if (rst) begin
         req <= 1'b0;
      end else if (sample) begin
         req <= 1'b1;
      end else if (grant) begin
         req <= 1'b0;
      end
   end

endmodule

//--- src/nrm_sample_timer.sv
// --------------------
// sample timer
// free-running window counter that ends each
// measurement window with a one-cycle pulse
// --------------------

`timescale 1ns/1ps

module nrm_sample_timer (
   input  logic clk,
   input  logic rst,
   output logic sample
);

   logic [nrm_pkg::SAMPLE_CNT_WIDTH-1:0] cycle_cnt;
   logic                                 window_end;

   // last cycle of the window
   assign window_end = (cycle_cnt == nrm_pkg::SAMPLE_CNT_WIDTH'(nrm_pkg::SAMPLE_PERIOD - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         cycle_cnt <= '0;
         sample    <= 1'b0;
      end else begin
         // pulse follows the last window cycle, so the first one
         // lands SAMPLE_PERIOD cycles after reset goes away
         sample <= window_end;
         if (window_end) begin
            cycle_cnt <= '0;
         end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
         end
      end
   end

endmodule

//--- src/nrm_stats_arbiter.sv
// --------------------
// statistics arbiter
// fixed-priority grant among the collectors,
// lowest link first, and the buffer write
// --------------------

`timescale 1ns/1ps

module nrm_stats_arbiter (
   input  logic                                                  clk,
   input  logic                                                  rst,
   input  logic [nrm_pkg::NUM_LINKS-1:0]                         req,
   input  logic [nrm_pkg::NUM_LINKS*nrm_pkg::COUNT_WIDTH-1:0]    count,
   output logic [nrm_pkg::NUM_LINKS-1:0]                         grant,
   output logic                                                  wr_en,
   output logic [nrm_pkg::RECORD_WIDTH-1:0]                      wr_record
);

   logic [nrm_pkg::LINK_ID_WIDTH-1:0]   sel_link;
   logic [nrm_pkg::COUNT_WIDTH-1:0]     sel_count;
   logic                                found;
   logic [nrm_pkg::BURST_CNT_WIDTH-1:0] burst_cnt;

   // scan from link 0 upwards, first request wins
   always_comb begin
      grant    = '0;
      sel_link = '0;
      found    = 1'b0;
      for (int i = 0; i < nrm_pkg::NUM_LINKS; i++) begin
         if (req[i] && !found) begin
            grant[i] = 1'b1;
            sel_link = nrm_pkg::LINK_ID_WIDTH'(i);
            found    = 1'b1;
         end
      end
   end

   // count of the winning collector
   assign sel_count = count[sel_link*nrm_pkg::COUNT_WIDTH +: nrm_pkg::COUNT_WIDTH];

   // write goes out in the same cycle as the grant
   assign wr_en     = found;
   assign wr_record = {sel_link, sel_count};

   // grants in the current burst of requests
   // back to zero once all requests are served
   always_ff @(posedge clk) begin
      if (rst) begin
         burst_cnt <= '0;
      end else if (!found) begin
         burst_cnt <= '0;
      end else begin
         burst_cnt <= burst_cnt + 1'b1;
      end
   end

endmodule

//--- src/nrm_stats_buffer.sv
// --------------------
// statistics buffer
// show-ahead FIFO of records for the debug reader
// drops writes when full and keeps a sticky lost flag
// --------------------

`timescale 1ns/1ps

module nrm_stats_buffer (
   input  logic                                  clk,
   input  logic                                  rst,
   // write side from the arbiter
   input  logic                                  wr_en,
   input  logic [nrm_pkg::RECORD_WIDTH-1:0]      wr_record,
   // read side, plain strobe
   input  logic                                  rd,
   output logic [nrm_pkg::LINK_ID_WIDTH-1:0]     rd_link,
   output logic [nrm_pkg::COUNT_WIDTH-1:0]       rd_count,
   // status
   output logic                                  empty,
   output logic                                  full,
   output logic                                  lost
);

   logic [nrm_pkg::RECORD_WIDTH-1:0]     mem [nrm_pkg::BUF_DEPTH];
   logic [nrm_pkg::BUF_ADDR_WIDTH-1:0]   wr_ptr;
   logic [nrm_pkg::BUF_ADDR_WIDTH-1:0]   rd_ptr;
   logic [nrm_pkg::BUF_LEVEL_WIDTH-1:0]  fill_level;
   logic [nrm_pkg::RECORD_WIDTH-1:0]     head;
   logic                                 do_wr;
   logic                                 do_rd;

   assign empty = (fill_level == '0);
   assign full  = (fill_level == nrm_pkg::BUF_LEVEL_WIDTH'(nrm_pkg::BUF_DEPTH));

   // a full buffer drops, an empty one ignores reads
   assign do_wr = wr_en && !full;
   assign do_rd = rd && !empty;

   // oldest record, visible while not empty
   assign head     = mem[rd_ptr];
   assign rd_link  = head[nrm_pkg::RECORD_LINK_LSB +: nrm_pkg::LINK_ID_WIDTH];
   assign rd_count = head[nrm_pkg::RECORD_COUNT_LSB +: nrm_pkg::COUNT_WIDTH];

   // record storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_record;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill_level <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // level moves only when exactly one side acts
         if (do_wr && !do_rd) begin
            fill_level <= fill_level + 1'b1;
         end else if (do_rd && !do_wr) begin
            fill_level <= fill_level - 1'b1;
         end
      end
   end

   // set by any dropped record, cleared only by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         lost <= 1'b0;
      end else if (wr_en && full) begin
         lost <= 1'b1;
      end
   end

endmodule

//--- src/nrm_top.sv
// --------------------
// network router monitor
// sample timer, one statistics collector per link,
// arbiter and the shared statistics buffer
// --------------------

`timescale 1ns/1ps

module nrm_top (
   input  logic                                                     clk,
   input  logic                                                     rst,
   // router links, one slice per link
   input  logic [nrm_pkg::NUM_LINKS*nrm_pkg::NOC_FLIT_WIDTH-1:0]    link_flit,
   input  logic [nrm_pkg::NUM_LINKS*nrm_pkg::NOC_VCHANNELS-1:0]     link_valid,
   input  logic [nrm_pkg::NUM_LINKS*nrm_pkg::NOC_VCHANNELS-1:0]     link_ready,
   // debug reader
   input  logic                                                     rd,
   output logic                                                     sample,
   output logic [nrm_pkg::LINK_ID_WIDTH-1:0]                        rd_link,
   output logic [nrm_pkg::COUNT_WIDTH-1:0]                          rd_count,
   output logic                                                     empty,
   output logic                                                     full,
   output logic                                                     lost
);

   logic [nrm_pkg::NUM_LINKS-1:0]                        stat_req;
   logic [nrm_pkg::NUM_LINKS-1:0]                        stat_grant;
   logic [nrm_pkg::NUM_LINKS*nrm_pkg::COUNT_WIDTH-1:0]   stat_count;
   logic                                                 wr_en;
   logic [nrm_pkg::RECORD_WIDTH-1:0]                     wr_record;

   // window end, shared by all collectors
   nrm_sample_timer nrm_sample_timer_inst (
      .clk    (clk),
      .rst    (rst),
      .sample (sample)
   );

   // one collector per link, each on its own slice
   for (genvar i = 0; i < nrm_pkg::NUM_LINKS; i++) begin : gen_link
      nrm_link_statistics_collector nrm_link_statistics_collector_inst (
         .clk        (clk),
         .rst        (rst),
         .flit       (link_flit[i*nrm_pkg::NOC_FLIT_WIDTH +: nrm_pkg::NOC_FLIT_WIDTH]),
         .valid      (link_valid[i*nrm_pkg::NOC_VCHANNELS +: nrm_pkg::NOC_VCHANNELS]),
         .ready      (link_ready[i*nrm_pkg::NOC_VCHANNELS +: nrm_pkg::NOC_VCHANNELS]),
         .sample     (sample),
         .grant      (stat_grant[i]),
         .req        (stat_req[i]),
         .sent_flits (stat_count[i*nrm_pkg::COUNT_WIDTH +: nrm_pkg::COUNT_WIDTH])
      );
   end

   // serializes the pending records, link 0 first
   nrm_stats_arbiter nrm_stats_arbiter_inst (
      .clk       (clk),
      .rst       (rst),
      .req       (stat_req),
      .count     (stat_count),
      .grant     (stat_grant),
      .wr_en     (wr_en),
      .wr_record (wr_record)
   );

   // never stalls the arbiter, overflow is dropped
   nrm_stats_buffer nrm_stats_buffer_inst (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (wr_en),
      .wr_record (wr_record),
      .rd        (rd),
      .rd_link   (rd_link),
      .rd_count  (rd_count),
      .empty     (empty),
      .full      (full),
      .lost      (lost)
   );

endmodule

//--- verification/nrm_top_props.sv
// --------------------
// monitor properties
// grant, request and buffer rules
// checked on the arbiter and buffer nets
// --------------------

`timescale 1ns/1ps

module nrm_top_props (
   input logic                                clk,
   input logic                                rst,
   input logic [nrm_pkg::NUM_LINKS-1:0]       req,
   input logic [nrm_pkg::NUM_LINKS-1:0]       grant,
   input logic [nrm_pkg::BURST_CNT_WIDTH-1:0] burst_cnt,
   input logic                                wr_en,
   input logic                                rd,
   input logic                                full,
   input logic                                lost
);

   // at most one collector served per cycle
   a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
      else $error("more than one grant in a cycle");

   // one window never yields more records than there are links
   a_burst_limit: assert property (@(posedge clk) disable iff (rst)
                                   wr_en |-> burst_cnt < nrm_pkg::NUM_LINKS)
      else $error("more than %0d grants in one burst", nrm_pkg::NUM_LINKS);

   // each pending record waits for its grant
   for (genvar i = 0; i < nrm_pkg::NUM_LINKS; i++) begin : gen_req
      a_req_held: assert property (@(posedge clk) disable iff (rst)
                                   req[i] && !grant[i] |=> req[i])
         else $error("request fell before its grant");
   end

   // dropped write leaves the level alone
   a_full_drop: assert property (@(posedge clk) disable iff (rst)
                                 full && wr_en && !rd |=> full)
      else $error("write into a full buffer changed its level");

   // only the read moves the level
   a_full_read: assert property (@(posedge clk) disable iff (rst)
                                 full && wr_en && rd |=> !full)
      else $error("write into a full buffer was stored");

   // sticky until reset
   a_lost_sticky: assert property (@(posedge clk) disable iff (rst) !$fell(lost))
      else $error("lost flag cleared outside reset");

endmodule

bind nrm_top nrm_top_props nrm_top_props_inst (
   .clk       (clk),
   .rst       (rst),
   .req       (stat_req),
   .grant     (stat_grant),
   .burst_cnt (nrm_stats_arbiter_inst.burst_cnt),
   .wr_en     (wr_en),
   .rd        (rd),
   .full      (full),
   .lost      (lost)
);

//--- verification/nrm_tb.sv
// --------------------
// network router monitor testbench
// random link traffic and a random debug reader,
// checked against a window and buffer model
// --------------------

`timescale 1ns/1ps

module nrm_tb;

   localparam int CLK_HALF          = 50;
   localparam int COUNT_TOP         = (1 << nrm_pkg::COUNT_WIDTH) - 1;
   localparam int SAMPLE_WAIT_LIMIT = nrm_pkg::SAMPLE_PERIOD + 20;
   localparam int EMPTY_WAIT_LIMIT  = 16;
   localparam int DRAIN_LIMIT       = 4 * nrm_pkg::BUF_DEPTH;
   localparam int WRITE_SETTLE      = 6;
   localparam int PAUSED_WINDOWS    = 6;
   // reader modes
   localparam int READ_PAUSED       = 0;
   localparam int READ_RANDOM       = 1;
   localparam int READ_DRAIN        = 2;
   localparam int V                 = nrm_pkg::NOC_VCHANNELS;
   localparam int F                 = nrm_pkg::NOC_FLIT_WIDTH;

   logic                                    clk = 1'b0;
   logic                                    rst = 1'b1;
   logic [nrm_pkg::NUM_LINKS*F-1:0]         link_flit = '0;
   logic [nrm_pkg::NUM_LINKS*V-1:0]         link_valid = '0;
   logic [nrm_pkg::NUM_LINKS*V-1:0]         link_ready = '0;
   logic                                    rd = 1'b0;
   logic                                    sample;
   logic [nrm_pkg::LINK_ID_WIDTH-1:0]       rd_link;
   logic [nrm_pkg::COUNT_WIDTH-1:0]         rd_count;
   logic                                    empty;
   logic                                    full;
   logic                                    lost;

   int   seed = 30;
   int   read_mode = READ_PAUSED;
   // model state, owned by the clocked process
   int   run_cycles = 0;
   int   raw_cnt [nrm_pkg::NUM_LINKS];
   logic [nrm_pkg::RECORD_WIDTH-1:0] pend_q [$];
   logic [nrm_pkg::RECORD_WIDTH-1:0] exp_q [$];
   logic lost_exp = 1'b0;
   logic first_sample_seen = 1'b0;
   int   model_errors = 0;
   int   reads_checked = 0;
   int   dropped_records = 0;
   int   sat_windows = 0;
   int   edge_flits = 0;
   // flow state, owned by the main sequence
   int   flow_errors = 0;
   logic aborted = 1'b0;

   nrm_top nrm_top_inst (
      .clk        (clk),
      .rst        (rst),
      .link_flit  (link_flit),
      .link_valid (link_valid),
      .link_ready (link_ready),
      .rd         (rd),
      .sample     (sample),
      .rd_link    (rd_link),
      .rd_count   (rd_count),
      .empty      (empty),
      .full       (full),
      .lost       (lost)
   );

   initial begin
      forever #CLK_HALF clk = ~clk;
   end

   task automatic check_link(input string name, input logic [nrm_pkg::LINK_ID_WIDTH-1:0] act,
                             input logic [nrm_pkg::LINK_ID_WIDTH-1:0] exp);
      if (act !== exp) begin
         model_errors++;
         $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input logic [nrm_pkg::COUNT_WIDTH-1:0] act,
                              input logic [nrm_pkg::COUNT_WIDTH-1:0] exp);
      if (act !== exp) begin
         model_errors++;
         $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         model_errors++;
         $display("MISMATCH at %0t: %s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   // busy level per link, out of 128
   function automatic int activity_level(input int link);
      case (link)
         0:       return 125;
         1:       return 80;
         2:       return 45;
         default: return 12;
      endcase
   endfunction

   // one clock edge of the model, on the values seen just before the edge
   task automatic update_model();
      logic [V-1:0]                     hit;
      logic [nrm_pkg::RECORD_WIDTH-1:0] rec;
      logic [nrm_pkg::COUNT_WIDTH-1:0]  exp_cnt;
      logic                             was_full;
      if (rst) begin
         run_cycles = 0;
         pend_q.delete();
         exp_q.delete();
         lost_exp = 1'b0;
         first_sample_seen = 1'b0;
         for (int i = 0; i < nrm_pkg::NUM_LINKS; i++) begin
            raw_cnt[i] = 0;
         end
      end else begin
         check_flag("empty", empty, exp_q.size() == 0);
         check_flag("full", full, exp_q.size() == nrm_pkg::BUF_DEPTH);
         check_flag("lost", lost, lost_exp);
         // the first window is a whole period long
         if (sample && !first_sample_seen) begin
            first_sample_seen = 1'b1;
            if (run_cycles != nrm_pkg::SAMPLE_PERIOD) begin
               model_errors++;
               $display("first sample pulse came after %0d cycles, not %0d",
                        run_cycles, nrm_pkg::SAMPLE_PERIOD);
            end
         end
         was_full = (exp_q.size() == nrm_pkg::BUF_DEPTH);
         // reader pops the head record
         if (rd && exp_q.size() != 0) begin
            rec = exp_q.pop_front();
            check_link("rd_link", rd_link, rec[nrm_pkg::RECORD_WIDTH-1 -: nrm_pkg::LINK_ID_WIDTH]);
            check_count("rd_count", rd_count, rec[nrm_pkg::COUNT_WIDTH-1:0]);
            reads_checked++;
         end
         // one record of the closed window reaches the buffer per cycle
         if (pend_q.size() != 0) begin
            rec = pend_q.pop_front();
            if (was_full) begin
               lost_exp = 1'b1;
               dropped_records++;
            end else begin
               exp_q.push_back(rec);
            end
         end
         // sent flits, channels merged
         for (int i = 0; i < nrm_pkg::NUM_LINKS; i++) begin
            hit = link_valid[i*V +: V] & link_ready[i*V +: V];
            if (hit != '0) begin
               raw_cnt[i]++;
               if (sample && i == nrm_pkg::NUM_LINKS - 1) begin
                  edge_flits++;
               end
            end
         end
         // window closes, the sample cycle belongs to it
         if (sample) begin
            for (int i = 0; i < nrm_pkg::NUM_LINKS; i++) begin
               if (raw_cnt[i] > COUNT_TOP) begin
                  exp_cnt = nrm_pkg::COUNT_WIDTH'(COUNT_TOP);
                  if (i == 0) begin
                     sat_windows++;
                  end
               end else begin
                  exp_cnt = nrm_pkg::COUNT_WIDTH'(raw_cnt[i]);
               end
               pend_q.push_back({nrm_pkg::LINK_ID_WIDTH'(i), exp_cnt});
               raw_cnt[i] = 0;
            end
         end
         run_cycles++;
      end
   endtask

   // model first, then the inputs for the next cycle
   always @(posedge clk) begin : model_and_stimulus
      logic [nrm_pkg::NUM_LINKS*F-1:0] next_flit;
      logic [nrm_pkg::NUM_LINKS*V-1:0] next_valid;
      logic [nrm_pkg::NUM_LINKS*V-1:0] next_ready;
      logic [V-1:0]                    valid_bits;
      logic [V-1:0]                    ready_bits;
      logic [31:0]                     vr;
      logic [63:0]                     fr;
      logic                            active;
      logic                            next_rd;
      int                              ch;
      update_model();
      for (int i = 0; i < nrm_pkg::NUM_LINKS; i++) begin
         vr = $random(seed);
         active = (int'(vr[6:0]) < activity_level(i));
         // link 3 sends in the sample cycle and in the cycle after it
         if (i == nrm_pkg::NUM_LINKS - 1 && (run_cycles % nrm_pkg::SAMPLE_PERIOD) <= 1) begin
            active = 1'b1;
         end
         vr = $random(seed);
         ch = int'(vr[15:8]) % V;
         valid_bits = vr[V-1:0];
         if (active) begin
            ready_bits = vr[16 +: V];
            valid_bits[ch] = 1'b1;
            ready_bits[ch] = 1'b1;
         end else begin
            ready_bits = ~valid_bits;
         end
         fr = {$random(seed), $random(seed)};
         next_flit[i*F +: F]  = fr[F-1:0];
         next_valid[i*V +: V] = valid_bits;
         next_ready[i*V +: V] = ready_bits;
      end
      vr = $random(seed);
      case (read_mode)
         READ_RANDOM: next_rd = !empty && (vr[1:0] == 2'b00);
         READ_DRAIN:  next_rd = !empty;
         default:     next_rd = 1'b0;
      endcase
      link_flit  <= next_flit;
      link_valid <= next_valid;
      link_ready <= next_ready;
      rd         <= next_rd;
   end

   task automatic wait_for_sample(input int limit);
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!sample && cycles < limit);
      if (!sample) begin
         flow_errors++;
         aborted = 1'b1;
         $display("timeout: no sample pulse within %0d cycles", limit);
      end
   endtask

   task automatic wait_not_empty(input int limit);
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (empty && cycles < limit);
      if (empty) begin
         flow_errors++;
         aborted = 1'b1;
         $display("timeout: buffer stayed empty for %0d cycles after a sample", limit);
      end
   endtask

   // read back to back until the buffer shows empty
   task automatic drain_buffer(input int limit);
      int cycles;
      cycles = 0;
      read_mode <= READ_DRAIN;
      do begin
         @(posedge clk);
         cycles++;
      end while (!empty && cycles < limit);
      if (!empty) begin
         flow_errors++;
         aborted = 1'b1;
         $display("timeout: buffer not drained within %0d cycles", limit);
      end
   endtask

   task automatic run_phases();
      read_mode <= READ_RANDOM;
      repeat (3) begin
         wait_for_sample(SAMPLE_WAIT_LIMIT);
         if (aborted) return;
      end
      wait_not_empty(EMPTY_WAIT_LIMIT);
      if (aborted) return;
      repeat (WRITE_SETTLE) @(posedge clk);
      drain_buffer(DRAIN_LIMIT);
      if (aborted) return;
      // reader silent long enough to overflow the buffer
      read_mode <= READ_PAUSED;
      repeat (PAUSED_WINDOWS) begin
         wait_for_sample(SAMPLE_WAIT_LIMIT);
         if (aborted) return;
      end
      repeat (WRITE_SETTLE) @(posedge clk);
      if (!full || !lost) begin
         flow_errors++;
         $display("buffer did not fill and drop records while the reader was paused");
      end
      // reading resumes inside the next write burst, so reads meet a full buffer
      wait_for_sample(SAMPLE_WAIT_LIMIT);
      if (aborted) return;
      drain_buffer(DRAIN_LIMIT);
      if (aborted) return;
      // back to normal reading, lost must stay set
      read_mode <= READ_RANDOM;
      repeat (2) begin
         wait_for_sample(SAMPLE_WAIT_LIMIT);
         if (aborted) return;
      end
      repeat (WRITE_SETTLE) @(posedge clk);
      drain_buffer(DRAIN_LIMIT);
   endtask

   task automatic check_coverage();
      if (sat_windows == 0) begin
         flow_errors++;
         $display("link 0 never went past the count limit");
      end
      if (dropped_records == 0) begin
         flow_errors++;
         $display("no record was dropped during the paused phase");
      end
      if (edge_flits == 0) begin
         flow_errors++;
         $display("no flit was sent in a sample cycle");
      end
      if (reads_checked < nrm_pkg::BUF_DEPTH) begin
         flow_errors++;
         $display("only %0d records were read back", reads_checked);
      end
   endtask

   initial begin : main_flow
      int total;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      run_phases();
      if (!aborted) begin
         check_coverage();
      end
      total = model_errors + flow_errors;
      $display("errors: %0d  records read: %0d  records dropped: %0d",
               total, reads_checked, dropped_records);
      if (total == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- sim.f
src/nrm_pkg.sv
src/nrm_link_statistics_collector.sv
src/nrm_sample_timer.sv
src/nrm_stats_arbiter.sv
src/nrm_stats_buffer.sv
src/nrm_top.sv
verification/nrm_top_props.sv
verification/nrm_tb.sv

//--- Makefile
# Verilator build and run of the network router monitor testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := nrm_tb
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := No errors

# sources named in the file list, so the binary follows their changes
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@if grep -qx "$(PASS_MSG)" $(SIM_LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
